//--- Bender.yml
package:
  name: alu_exec

sources:
  - aluPkg.sv
  - pipeStage.sv
  - opDecode.sv
  - intAlu.sv
  - seqMulDiv.sv
  - execStage.sv
  - apbExecPort.sv
  - aluTop.sv
  - target: test
    files:
      - aluTb.sv

//--- aluPkg.sv
package aluPkg;

    // ======================================================================
    // widths and iteration count
    // ======================================================================
    localparam int dataW = 32;
    localparam int addrW = 8;
    localparam int mulDivCycles = 32;

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, CMP, CMPU, SHL,
        SHR, ASR, CLZ, POP, MUL, MULU, DIV, DIVU
    } opcodeE;

    typedef enum logic [1:0] {szByte, szHalf, szWord} sizeE;

    typedef enum logic [1:0] {fltNone, fltOfl, fltDbz} faultE;

    // opcode in bits 5:0, size in bits 7:6
    typedef struct packed {
        logic [23:0] rsvd;
        sizeE        size;
        opcodeE      opcode;
    } instrT;

    typedef struct packed {
        logic dbzEn;
        logic oflEn;
    } excEnT;

    typedef struct packed {
        instrT            instr;
        logic [dataW-1:0] opA;
        logic [dataW-1:0] opB;
        excEnT            excEn;
    } issueT;

    typedef struct packed {
        opcodeE           opcode;
        sizeE             size;
        logic [dataW-1:0] opA;
        logic [dataW-1:0] opB;
        logic             isMulDiv;
        logic             isSigned;
        excEnT            excEn;
    } execCmdT;

    typedef struct packed {
        logic [dataW-1:0] resLo;
        logic [dataW-1:0] resHi;
        faultE            fault;
    } resultT;

    // ======================================================================
    // register map
    // ======================================================================
    localparam logic [addrW-1:0] regOpA    = 8'h00;
    localparam logic [addrW-1:0] regOpB    = 8'h04;
    localparam logic [addrW-1:0] regInstr  = 8'h08;
    localparam logic [addrW-1:0] regExcEn  = 8'h0C;
    localparam logic [addrW-1:0] regResLo  = 8'h10;
    localparam logic [addrW-1:0] regResHi  = 8'h14;
    localparam logic [addrW-1:0] regStatus = 8'h18;

    // widen a byte or half value to the datapath, word passes unchanged
    function automatic logic [dataW-1:0] extend(
        input logic [dataW-1:0] v,
        input sizeE             sz,
        input logic             sgn
    );
        case (sz)
            szByte:  return {{(dataW-8){sgn & v[7]}}, v[7:0]};
            szHalf:  return {{(dataW-16){sgn & v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

endpackage

//--- aluTb.sv
`timescale 1ns/1ps

module aluTb;
    import aluPkg::*;

    localparam int readyLimit = 200;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [addrW-1:0]     paddr;
    logic [dataW-1:0]     pwdata;
    logic [dataW-1:0]     prdata;
    logic                 pready;
    logic                 pslverr;

    integer seed;
    int     errors;
    int     checks;
    logic   expSticky;

    // operand pairs, taken index by index
    logic [31:0] edgeA [7] = '{32'h0, 32'h7fffffff, 32'h80000000, 32'hffffffff,
                               32'h00000080, 32'h12345678, 32'hfffffff9};
    logic [31:0] edgeB [7] = '{32'h0, 32'h1, 32'hffffffff, 32'd31,
                               32'h00008000, 32'h0000007f, 32'h3};

    aluTop dut_i (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [31:0] sizeExt(input logic [31:0] v, input sizeE sz,
                                            input logic sgn);
        int          w;
        logic [31:0] r;
        w = (sz == szByte) ? 8 : (sz == szHalf) ? 16 : 32;
        r = v;
        for (int i = w; i < 32; i++)
            r[i] = sgn & v[w-1];
        return r;
    endfunction

    function automatic resultT refModel(input opcodeE op, input sizeE sz,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic oflEn, input logic dbzEn);
        logic        sgn;
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] p;
        longint      sa;
        longint      sb;
        int          w;
        logic        ofl;
        logic        dbz;
        resultT      r;
        sgn = !(op inside {CMPU, SHR, CLZ, POP, MULU, DIVU});
        ea  = sizeExt(a, sz, sgn);
        eb  = sizeExt(b, sz, sgn);
        sa  = $signed(ea);
        sb  = $signed(eb);
        w   = (sz == szByte) ? 8 : (sz == szHalf) ? 16 : 32;
        hi  = '0;
        ofl = 1'b0;
        dbz = 1'b0;
        case (op)
            ADD: begin
                lo  = sizeExt(ea + eb, sz, 1'b1);
                ofl = (ea[31] == eb[31]) && (lo[31] != ea[31]);
            end
            SUB: begin
                lo  = sizeExt(ea - eb, sz, 1'b1);
                ofl = (ea[31] != eb[31]) && (lo[31] != ea[31]);
            end
            AND:  lo = sizeExt(ea & eb, sz, 1'b1);
            OR:   lo = sizeExt(ea | eb, sz, 1'b1);
            XOR:  lo = sizeExt(ea ^ eb, sz, 1'b1);
            CMP:  lo = (sa < sb) ? 32'hffffffff : (sa == sb) ? 32'd0 : 32'd1;
            CMPU: lo = (ea < eb) ? 32'hffffffff : (ea == eb) ? 32'd0 : 32'd1;
            SHL:  lo = sizeExt(ea << eb[4:0], sz, 1'b1);
            SHR:  lo = sizeExt(ea >> eb[4:0], sz, 1'b1);
            ASR:  lo = sizeExt(32'(sa >>> eb[4:0]), sz, 1'b1);
            CLZ: begin
                lo = 32'd0;
                for (int i = w - 1; i >= 0 && !ea[i]; i--)
                    lo++;
            end
            POP: begin
                lo = 32'd0;
                for (int i = 0; i < 32; i++)
                    lo = lo + ea[i];
            end
            MUL, MULU: begin
                p   = (op == MUL) ? 64'(sa * sb) : {32'd0, ea} * {32'd0, eb};
                lo  = p[31:0];
                hi  = p[63:32];
                ofl = (op == MUL) ? (hi != {32{lo[31]}}) : (hi != 32'd0);
            end
            DIV, DIVU: begin
                dbz = (eb == 32'd0);
                if (dbz) begin
                    lo = 32'hffffffff;
                    hi = ea;
                end else if (op == DIV) begin
                    p  = 64'(sa / sb);
                    lo = p[31:0];
                    p  = 64'(sa % sb);
                    hi = p[31:0];
                end else begin
                    lo = ea / eb;
                    hi = ea % eb;
                end
            end
            default: lo = 32'd0;
        endcase
        r.resLo = lo;
        r.resHi = hi;
        r.fault = (ofl && oflEn) ? fltOfl : (dbz && dbzEn) ? fltDbz : fltNone;
        return r;
    endfunction

    // ======================================================================
    // bus tasks and checks
    // ======================================================================
    task automatic endRun();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // sample at the falling edge, where pready and prdata are settled
    task automatic waitReady(input logic [7:0] addr, output int waits);
        waits = 0;
        @(negedge clk);
        while (!pready && waits < readyLimit) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("timeout: pready stayed low for %0d cycles at address %h", waits, addr);
            errors++;
            endRun();
        end
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                            output int waits, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        waitReady(addr, waits);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        waitReady(addr, waits);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // result registers and status after a retired instruction
    task automatic checkResult(input resultT exp, input string tag);
        logic [31:0] got;
        logic        err;
        readReg(regResLo, got, err);
        checkValue({"resLo ", tag}, got, exp.resLo);
        readReg(regResHi, got, err);
        checkValue({"resHi ", tag}, got, exp.resHi);
        if (exp.fault != fltNone)
            expSticky = 1'b1;
        readReg(regStatus, got, err);
        checkValue({"status ", tag}, got, {25'd0, expSticky, exp.fault, 4'd0});
    endtask

    task automatic runOp(input opcodeE op, input sizeE sz, input logic [31:0] a,
                         input logic [31:0] b, input logic oflEn, input logic dbzEn);
        int   waits;
        logic err;
        writeReg(regOpA, a, waits, err);
        writeReg(regOpB, b, waits, err);
        writeReg(regExcEn, {30'd0, dbzEn, oflEn}, waits, err);
        writeReg(regInstr, {24'd0, sz, op}, waits, err);
        checkResult(refModel(op, sz, a, b, oflEn, dbzEn),
                    $sformatf("(op %0d size %0d a %h b %h)", op, sz, a, b));
    endtask

    // every operand pair plus two random ones, both fault enables set
    task automatic sweepOp(input opcodeE op);
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 7; k++)
                runOp(op, sizeE'(s), edgeA[k], edgeB[k], 1'b1, 1'b1);
            repeat (2)
                runOp(op, sizeE'(s), $random(seed), $random(seed), 1'b1, 1'b1);
        end
    endtask

    task automatic clearSticky();
        int          waits;
        logic        err;
        logic [31:0] got;
        writeReg(regStatus, 32'h40, waits, err);
        expSticky = 1'b0;
        readReg(regStatus, got, err);
        checkValue("status sticky bit after clear", got[6], 1'b0);
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] a;
        logic [31:0] b;
        logic        err;
        int          waits;
        seed      = 76650;
        errors    = 0;
        checks    = 0;
        expSticky = 1'b0;
        rstN      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // reset state and bad accesses
        readReg(regStatus, got, err);
        checkValue("status after reset", got, 32'd0);
        readReg(regResLo, got, err);
        checkValue("resLo after reset", got, 32'd0);
        readReg(regResHi, got, err);
        checkValue("resHi after reset", got, 32'd0);
        readReg(8'h1C, got, err);
        checkValue("pslverr on unmapped read", 32'(err), 32'd1);
        writeReg(regResLo, 32'h5a5a5a5a, waits, err);
        checkValue("pslverr on resLo write", 32'(err), 32'd1);

        for (int o = ADD; o <= DIVU; o++)
            sweepOp(opcodeE'(o));

        // faults gated by their enables, then the sticky clear
        clearSticky();
        for (int en = 0; en < 2; en++) begin
            runOp(ADD, szWord, 32'h7fffffff, 32'h1, en[0], en[0]);
            runOp(ADD, szByte, 32'h7f, 32'h1, en[0], en[0]);
            runOp(SUB, szWord, 32'h80000000, 32'h1, en[0], en[0]);
            runOp(MUL, szWord, 32'h10000, 32'h10000, en[0], en[0]);
            runOp(MULU, szWord, 32'hffffffff, 32'h2, en[0], en[0]);
            runOp(DIV, szWord, 32'hfffffff9, 32'h0, en[0], en[0]);
        end
        clearSticky();

        // four issues in a row behind a multiply, the last one stalls
        a = $random(seed);
        b = $random(seed);
        writeReg(regOpA, a, waits, err);
        writeReg(regOpB, b, waits, err);
        writeReg(regExcEn, 32'd0, waits, err);
        writeReg(regInstr, {24'd0, szWord, MUL}, waits, err);
        writeReg(regInstr, {24'd0, szWord, ADD}, waits, err);
        writeReg(regInstr, {24'd0, szWord, XOR}, waits, err);
        writeReg(regInstr, {24'd0, szWord, SUB}, waits, err);
        checks++;
        assert (waits > 0) else begin
            errors++;
            $display("the fourth instruction write was accepted without a wait state");
        end
        checkResult(refModel(SUB, szWord, a, b, 1'b0, 1'b0), "back-to-back");

        endRun();
    end

endmodule

//--- aluTop.sv
`timescale 1ns/1ps

module aluTop (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [aluPkg::addrW-1:0] paddr,
    input  logic [aluPkg::dataW-1:0] pwdata,
    output logic [aluPkg::dataW-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr
);
    import aluPkg::*;

    logic    issueValid;
    logic    issueReady;
    issueT   issue;
    logic    decInValid;
    logic    decInReady;
    issueT   decIn;
    logic    decOutValid;
    logic    decOutReady;
    execCmdT decCmd;
    logic    exInValid;
    logic    exInReady;
    execCmdT exCmd;
    logic    retireValid;
    resultT  retire;

    apbExecPort port_i (
        .clk         (clk),
        .rstN        (rstN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .issueValid  (issueValid),
        .issue       (issue),
        .issueReady  (issueReady),
        .retireValid (retireValid),
        .retire      (retire)
    );

    // ======================================================================
    // issue register, decode, command register, execute
    // ======================================================================
    pipeStage #(.payloadT(issueT)) issueStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (issueValid),
        .inData   (issue),
        .outReady (decInReady),
        .inReady  (issueReady),
        .outValid (decInValid),
        .outData  (decIn)
    );

    opDecode decode_i (
        .inValid  (decInValid),
        .in       (decIn),
        .outReady (decOutReady),
        .inReady  (decInReady),
        .outValid (decOutValid),
        .out      (decCmd)
    );

    pipeStage #(.payloadT(execCmdT)) cmdStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (decOutValid),
        .inData   (decCmd),
        .outReady (exInReady),
        .inReady  (decOutReady),
        .outValid (exInValid),
        .outData  (exCmd)
    );

    // results always retire, the port never stalls them
    execStage exec_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (exInValid),
        .cmd      (exCmd),
        .outReady (1'b1),
        .inReady  (exInReady),
        .outValid (retireValid),
        .res      (retire)
    );

endmodule

//--- apbExecPort.sv
`timescale 1ns/1ps

module apbExecPort (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [aluPkg::addrW-1:0] paddr,
    input  logic [aluPkg::dataW-1:0] pwdata,
    output logic [aluPkg::dataW-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     issueValid,
    output aluPkg::issueT            issue,
    input  logic                     issueReady,
    input  logic                     retireValid,
    input  aluPkg::resultT           retire
);
    import aluPkg::*;

    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] resLo;
    logic [dataW-1:0] resHi;
    excEnT            excEn;
    faultE            lastFault;
    logic             sticky;
    logic [3:0]       inFlight;
    logic             access;
    logic             mapped;
    logic             resAddr;
    logic             issueFire;

    assign access  = psel && penable;
    assign mapped  = paddr inside {regOpA, regOpB, regInstr, regExcEn,
                                   regResLo, regResHi, regStatus};
    assign resAddr = paddr inside {regResLo, regResHi};

    // instruction write issues straight from the bus
    assign issueValid = access && pwrite && (paddr == regInstr);
    assign issueFire  = issueValid && issueReady;
    assign issue      = '{instr: instrT'(pwdata), opA: opA, opB: opB, excEn: excEn};

    // wait states: issue back-pressure, result reads wait for an empty pipe
    assign pready  = access && (issueValid ? issueReady :
                                (!pwrite && resAddr) ? (inFlight == 4'd0) : 1'b1);
    assign pslverr = access && (!mapped || (pwrite && resAddr));

    always_comb begin
        case (paddr)
            regOpA:    prdata = opA;
            regOpB:    prdata = opB;
            regExcEn:  prdata = {{(dataW-2){1'b0}}, excEn};
            regResLo:  prdata = resLo;
            regResHi:  prdata = resHi;
            regStatus: prdata = {{(dataW-7){1'b0}}, sticky, lastFault, inFlight};
            default:   prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opA       <= '0;
            opB       <= '0;
            excEn     <= '0;
            resLo     <= '0;
            resHi     <= '0;
            lastFault <= fltNone;
            sticky    <= 1'b0;
            inFlight  <= '0;
        end else begin
            inFlight <= inFlight + 4'(issueFire) - 4'(retireValid);
            if (access && pwrite) begin
                case (paddr)
                    regOpA:    opA <= pwdata;
                    regOpB:    opB <= pwdata;
                    regExcEn:  excEn <= excEnT'(pwdata[1:0]);
                    regStatus: if (pwdata[6]) sticky <= 1'b0;
                    default:   ;
                endcase
            end
            // a fault retiring in the same cycle wins over the clear
            if (retireValid) begin
                resLo     <= retire.resLo;
                resHi     <= retire.resHi;
                lastFault <= retire.fault;
                if (retire.fault != fltNone)
                    sticky <= 1'b1;
            end
        end
    end

endmodule

//--- execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  aluPkg::execCmdT cmd,
    input  logic            outReady,
    output logic            inReady,
    output logic            outValid,
    output aluPkg::resultT  res
);
    import aluPkg::*;

    resultT           aluRes;
    resultT           mdRes;
    logic             start;
    logic             busy;
    logic             done;
    logic             dbz;
    logic [dataW-1:0] mdLo;
    logic [dataW-1:0] mdHi;
    logic             mdWait;
    logic             mdDiv;
    logic             mdSigned;
    excEnT            mdEn;

    intAlu alu_i (
        .cmd (cmd),
        .res (aluRes)
    );

    seqMulDiv mulDiv_i (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .isDiv      (cmd.opcode inside {DIV, DIVU}),
        .isSigned   (cmd.isSigned),
        .a          (cmd.opA),
        .b          (cmd.opB),
        .busy       (busy),
        .done       (done),
        .prodOrQuot (mdLo),
        .remOrHigh  (mdHi),
        .divByZero  (dbz)
    );

    // a multiply or divide blocks the stage until its result retires
    assign inReady  = !busy && !mdWait && (cmd.isMulDiv || outReady);
    assign start    = inValid && inReady && cmd.isMulDiv;
    assign outValid = mdWait ? done : (inValid && !cmd.isMulDiv);
    assign res      = mdWait ? mdRes : aluRes;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            mdWait <= 1'b0;
        else if (start)
            mdWait <= 1'b1;
        else if (mdWait && done && outReady)
            mdWait <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mdDiv    <= cmd.opcode inside {DIV, DIVU};
            mdSigned <= cmd.isSigned;
            mdEn     <= cmd.excEn;
        end
    end

    always_comb begin
        mdRes.resLo = mdLo;
        mdRes.resHi = mdHi;
        mdRes.fault = fltNone;
        if (mdDiv) begin
            if (dbz && mdEn.dbzEn)
                mdRes.fault = fltDbz;
        end else if (mdEn.oflEn) begin
            // high word must be the sign extension of the low word, or zero
            if (mdSigned ? (mdHi != {dataW{mdLo[dataW-1]}}) : (mdHi != '0))
                mdRes.fault = fltOfl;
        end
    end

endmodule

//--- files.f
aluPkg.sv
pipeStage.sv
opDecode.sv
intAlu.sv
seqMulDiv.sv
execStage.sv
apbExecPort.sv
aluTop.sv
aluTb.sv

//--- intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  aluPkg::execCmdT cmd,
    output aluPkg::resultT  res
);
    import aluPkg::*;

    logic [dataW-1:0] a;
    logic [dataW-1:0] b;
    logic [dataW-1:0] sum;
    logic [dataW-1:0] diff;
    logic [4:0]       shAmt;
    logic [5:0]       clzCnt;
    logic [5:0]       popCnt;
    logic [5:0]       clzAdj;
    logic             ofl;

    assign a     = cmd.opA;
    assign b     = cmd.opB;
    assign sum   = a + b;
    assign diff  = a - b;
    assign shAmt = b[4:0];

    // counts over the zero-extended operand
    always_comb begin : counts
        logic seen;
        seen   = 1'b0;
        clzCnt = '0;
        popCnt = '0;
        for (int i = dataW - 1; i >= 0; i--) begin
            if (a[i])
                seen = 1'b1;
            if (!seen)
                clzCnt = clzCnt + 6'd1;
            popCnt = popCnt + 6'(a[i]);
        end
    end

    // leading zeros above the sized field are not counted
    always_comb begin
        case (cmd.size)
            szByte:  clzAdj = 6'd24;
            szHalf:  clzAdj = 6'd16;
            default: clzAdj = 6'd0;
        endcase
    end

    always_comb begin
        res.resHi = '0;
        case (cmd.opcode)
            ADD:     res.resLo = extend(sum, cmd.size, 1'b1);
            SUB:     res.resLo = extend(diff, cmd.size, 1'b1);
            AND:     res.resLo = extend(a & b, cmd.size, 1'b1);
            OR:      res.resLo = extend(a | b, cmd.size, 1'b1);
            XOR:     res.resLo = extend(a ^ b, cmd.size, 1'b1);
            CMP:     res.resLo = ($signed(a) < $signed(b)) ? '1 :
                                 (a == b) ? '0 : dataW'(1);
            CMPU:    res.resLo = (a < b) ? '1 : (a == b) ? '0 : dataW'(1);
            SHL:     res.resLo = extend(a << shAmt, cmd.size, 1'b1);
            SHR:     res.resLo = extend(a >> shAmt, cmd.size, 1'b1);
            ASR:     res.resLo = extend(dataW'($signed(a) >>> shAmt), cmd.size, 1'b1);
            CLZ:     res.resLo = dataW'(clzCnt - clzAdj);
            POP:     res.resLo = dataW'(popCnt);
            default: res.resLo = '0;
        endcase

        // operands arrive sign-extended, so bit 31 is the sized sign
        ofl = 1'b0;
        if (cmd.opcode == ADD)
            ofl = (a[dataW-1] == b[dataW-1]) && (res.resLo[dataW-1] != a[dataW-1]);
        else if (cmd.opcode == SUB)
            ofl = (a[dataW-1] != b[dataW-1]) && (res.resLo[dataW-1] != a[dataW-1]);
        res.fault = (ofl && cmd.excEn.oflEn) ? fltOfl : fltNone;
    end

endmodule

//--- opDecode.sv
`timescale 1ns/1ps

module opDecode (
    input  logic            inValid,
    input  aluPkg::issueT   in,
    input  logic            outReady,
    output logic            inReady,
    output logic            outValid,
    output aluPkg::execCmdT out
);
    import aluPkg::*;

    opcodeE op;
    logic   known;
    logic   sgn;

    assign op    = in.instr.opcode;
    assign known = (op <= DIVU);

    // unsigned view for unsigned compare, logical shift, counts and the U ops
    assign sgn = !(op inside {CMPU, SHR, CLZ, POP, MULU, DIVU});

    assign inReady  = outReady;
    assign outValid = inValid;

    always_comb begin
        out.size     = in.instr.size;
        out.isSigned = sgn;
        out.excEn    = in.excEn;
        if (known) begin
            out.opcode   = op;
            out.opA      = extend(in.opA, in.instr.size, sgn);
            out.opB      = extend(in.opB, in.instr.size, sgn);
            out.isMulDiv = op inside {MUL, MULU, DIV, DIVU};
        end else begin
            // AND of zeros gives a zero result
            out.opcode   = AND;
            out.opA      = '0;
            out.opB      = '0;
            out.isMulDiv = 1'b0;
        end
    end

endmodule

//--- pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    input  logic    outReady,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData
);

    // accept when empty or when the held item leaves this cycle
    assign inReady = outReady || !outValid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            outValid <= 1'b0;
        else if (inReady)
            outValid <= inValid;
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady)
            outData <= inData;
    end

endmodule

//--- seqMulDiv.sv
`timescale 1ns/1ps

module seqMulDiv (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     start,
    input  logic                     isDiv,
    input  logic                     isSigned,
    input  logic [aluPkg::dataW-1:0] a,
    input  logic [aluPkg::dataW-1:0] b,
    output logic                     busy,
    output logic                     done,
    output logic [aluPkg::dataW-1:0] prodOrQuot,
    output logic [aluPkg::dataW-1:0] remOrHigh,
    output logic                     divByZero
);
    import aluPkg::*;

    localparam int cntW = $clog2(mulDivCycles);

    logic [cntW-1:0]    cnt;
    logic               aNeg;
    logic               bNeg;
    logic [dataW-1:0]   aMag;
    logic [dataW-1:0]   bMagIn;
    logic [dataW-1:0]   bMag;
    logic [dataW-1:0]   accHi;
    logic [dataW-1:0]   accLo;
    logic               divR;
    logic               negQ;
    logic               negR;
    logic [dataW:0]     mulSum;
    logic [dataW:0]     divShift;
    logic [dataW+1:0]   divDiff;
    logic [2*dataW-1:0] prod;

    assign aNeg   = isSigned && a[dataW-1];
    assign bNeg   = isSigned && b[dataW-1];
    assign aMag   = aNeg ? -a : a;
    assign bMagIn = bNeg ? -b : b;

    // one shift-add step, or one restoring subtract step
    assign mulSum   = {1'b0, accHi} + (accLo[0] ? {1'b0, bMag} : '0);
    assign divShift = {accHi, accLo[dataW-1]};
    assign divDiff  = {1'b0, divShift} - {2'b00, bMag};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == cntW'(mulDivCycles - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // accLo holds the multiplier or dividend, accHi the partial sum or remainder
    always_ff @(posedge clk) begin
        if (start) begin
            accHi     <= '0;
            accLo     <= aMag;
            bMag      <= bMagIn;
            divR      <= isDiv;
            negQ      <= aNeg ^ bNeg;
            negR      <= aNeg;
            divByZero <= isDiv && (b == '0);
        end else if (busy) begin
            if (!divR) begin
                accHi <= mulSum[dataW:1];
                accLo <= {mulSum[0], accLo[dataW-1:1]};
            end else if (!divDiff[dataW+1]) begin
                accHi <= divDiff[dataW-1:0];
                accLo <= {accLo[dataW-2:0], 1'b1};
            end else begin
                accHi <= divShift[dataW-1:0];
                accLo <= {accLo[dataW-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, a zero divisor forces an all-ones quotient
    assign prod       = negQ ? -{accHi, accLo} : {accHi, accLo};
    assign prodOrQuot = !divR ? prod[dataW-1:0] :
                        divByZero ? '1 : (negQ ? -accLo : accLo);
    assign remOrHigh  = !divR ? prod[2*dataW-1:dataW] : (negR ? -accHi : accHi);

endmodule
